//--- common/cp0_pkg.sv
`default_nettype none

package cp0_pkg;

    typedef logic [31:0] cp0_word_t;
    typedef logic [7:0]  cp0_addr_t;     // {rd, sel}

    // Register addresses as {rd, sel}
    localparam cp0_addr_t BADVADDR_ADDR = {5'd8, 3'd0};
    localparam cp0_addr_t COUNT_ADDR    = {5'd9, 3'd0};
    localparam cp0_addr_t COMPARE_ADDR  = {5'd11, 3'd0};
    localparam cp0_addr_t STATUS_ADDR   = {5'd12, 3'd0};
    localparam cp0_addr_t CAUSE_ADDR    = {5'd13, 3'd0};
    localparam cp0_addr_t EPC_ADDR      = {5'd14, 3'd0};
    localparam cp0_addr_t EBASE_ADDR    = {5'd15, 3'd1};

    typedef enum logic [4:0] {
        NONE = 5'd0,
        INT  = 5'd1,
        ADEL = 5'd2,
        ADES = 5'd3,
        SYS  = 5'd4,
        BP   = 5'd5,
        RI   = 5'd6,
        OV   = 5'd7
    } exc_type_e;

    // Cause.ExcCode encodings
    localparam logic [4:0] EXCCODE_INT  = 5'd0;
    localparam logic [4:0] EXCCODE_ADEL = 5'd4;
    localparam logic [4:0] EXCCODE_ADES = 5'd5;
    localparam logic [4:0] EXCCODE_SYS  = 5'd8;
    localparam logic [4:0] EXCCODE_BP   = 5'd9;
    localparam logic [4:0] EXCCODE_RI   = 5'd10;
    localparam logic [4:0] EXCCODE_OV   = 5'd12;

    localparam cp0_word_t BEV_EX_BASE       = 32'hBFC0_0200;
    localparam cp0_word_t GENERAL_EX_OFFSET = 32'h0000_0180;

    localparam cp0_word_t EBASE_RESET = 32'h8000_0000;
    localparam int        COUNT_DIV   = 2;

    typedef struct packed {
        logic      valid;
        logic      is_mtc0;
        logic      is_eret;
        logic      in_delay_slot;
        exc_type_e exc;
        cp0_addr_t rd_sel;
        cp0_word_t pc;
        cp0_word_t alu_result;             // MTC0 data or faulting address
    } mem_stage_t;

    typedef struct packed {
        logic      we;
        cp0_addr_t addr;
        cp0_word_t data;
    } cp0_write_t;

    typedef struct packed {
        logic       bev;
        logic [7:0] im;
        logic       exl;
        logic       ie;
        logic       bd;
        logic [4:0] exc_code;
        cp0_word_t  epc;
        cp0_word_t  badvaddr;
        cp0_word_t  ebase;
    } status_view_t;

    typedef struct packed {
        cp0_word_t  count;
        cp0_word_t  compare;
        logic       ti;
        logic [7:0] ip;
    } timer_view_t;

    function automatic logic [4:0] exc_code_of(exc_type_e kind);
        case (kind)
            INT:     return EXCCODE_INT;
            ADEL:    return EXCCODE_ADEL;
            ADES:    return EXCCODE_ADES;
            SYS:     return EXCCODE_SYS;
            BP:      return EXCCODE_BP;
            RI:      return EXCCODE_RI;
            OV:      return EXCCODE_OV;
            default: return 5'd0;       // NONE carries no code
        endcase
    endfunction

endpackage

`default_nettype wire

//--- compile.f
+incdir+sim
common/cp0_pkg.sv
exc/cp0_exception_unit.sv
timer/cp0_timer.sv
verilog/cp0_reg_view.sv
verilog/cp0_top.sv
sim/tb_cp0_checker.sv
sim/tb_cp0.sv

//--- exc/cp0_exception_unit.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_exception_unit #(
    parameter cp0_pkg::cp0_word_t EBASE_RESET = cp0_pkg::EBASE_RESET
) (
    input  wire                   clk,
    input  wire                   reset,
    input  cp0_pkg::mem_stage_t   mem,
    output cp0_pkg::cp0_write_t   wr,
    output cp0_pkg::status_view_t sv,
    output logic                  eret_flush
);

    logic               exc_taken;
    logic               no_exc;
    logic               status_we;
    logic               epc_we;
    logic               ebase_we;

    logic               bev;
    logic [7:0]         im;
    logic               exl;
    logic               ie;
    logic               bd;
    logic [4:0]         exc_code;
    cp0_pkg::cp0_word_t epc;
    cp0_pkg::cp0_word_t badvaddr;
    cp0_pkg::cp0_word_t ebase;

    assign no_exc    = (mem.exc == cp0_pkg::NONE);
    assign exc_taken = mem.valid && !no_exc;

    // The only place where an instruction is judged committed
    assign wr.we      = mem.valid && mem.is_mtc0 && no_exc;
    assign wr.addr    = mem.rd_sel;
    assign wr.data    = mem.alu_result;
    assign eret_flush = mem.valid && mem.is_eret && no_exc;

    assign status_we = wr.we && (wr.addr == cp0_pkg::STATUS_ADDR);
    assign epc_we    = wr.we && (wr.addr == cp0_pkg::EPC_ADDR);
    assign ebase_we  = wr.we && (wr.addr == cp0_pkg::EBASE_ADDR);

    always_ff @(posedge clk) begin
        if (reset) begin
            bev <= 1'b1;                            // Boot vectors after reset
            im  <= 8'h00;
            ie  <= 1'b0;
        end else if (status_we) begin
            bev <= wr.data[22];
            im  <= wr.data[15:8];
            ie  <= wr.data[0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exl <= 1'b0;
        end else if (exc_taken) begin
            exl <= 1'b1;
        end else if (eret_flush) begin
            exl <= 1'b0;
        end else if (status_we) begin
            exl <= wr.data[1];
        end
    end

    // Nested exceptions keep the first EPC and BD
    always_ff @(posedge clk) begin
        if (reset) begin
            bd <= 1'b0;
        end else if (exc_taken && !exl) begin
            bd <= mem.in_delay_slot;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exc_code <= 5'd0;
        end else if (exc_taken) begin
            exc_code <= cp0_pkg::exc_code_of(mem.exc);
        end
    end

    always_ff @(posedge clk) begin
        if (exc_taken && !exl) begin
            if (mem.exc == cp0_pkg::INT && mem.is_mtc0) begin
                epc <= mem.pc + 32'd4;              // Resume after the MTC0
            end else if (mem.in_delay_slot) begin
                epc <= mem.pc - 32'd4;              // Point at the branch
            end else begin
                epc <= mem.pc;
            end
        end else if (epc_we) begin
            epc <= wr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (exc_taken) begin
            if (mem.exc == cp0_pkg::ADES) begin
                badvaddr <= mem.alu_result;
            end else if (mem.exc == cp0_pkg::ADEL) begin
                // Fetch fault if the pc itself is misaligned
                badvaddr <= (mem.pc[1:0] != 2'b00) ? mem.pc : mem.alu_result;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ebase <= EBASE_RESET;
        end else if (ebase_we) begin
            ebase[29:12] <= wr.data[29:12];         // Only the base field is writable
        end
    end

    assign sv.bev      = bev;
    assign sv.im       = im;
    assign sv.exl      = exl;
    assign sv.ie       = ie;
    assign sv.bd       = bd;
    assign sv.exc_code = exc_code;
    assign sv.epc      = epc;
    assign sv.badvaddr = badvaddr;
    assign sv.ebase    = ebase;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the CP0 testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_cp0 -f compile.f -o tb_cp0 \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_cp0 > sim.log 2>&1
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"
exit 0

//--- sim/tb_cp0_cases.svh
`ifndef TB_CP0_CASES_SVH
`define TB_CP0_CASES_SVH

typedef struct {
    int                 op;
    cp0_pkg::cp0_addr_t addr;
    cp0_pkg::cp0_word_t data;
    cp0_pkg::cp0_word_t mask;       // Bits replaced by a random word
    cp0_pkg::cp0_word_t pc;
    cp0_pkg::exc_type_e exc;
    logic               ds;
    logic [5:0]         ext;
    cp0_pkg::cp0_word_t exp_rd;
    cp0_pkg::cp0_word_t exp_xa;
    logic               exp_flush;
    logic               exp_int;
} case_t;

localparam cp0_pkg::cp0_addr_t A_ST  = cp0_pkg::STATUS_ADDR;
localparam cp0_pkg::cp0_addr_t A_CA  = cp0_pkg::CAUSE_ADDR;
localparam cp0_pkg::cp0_addr_t A_EPC = cp0_pkg::EPC_ADDR;
localparam cp0_pkg::cp0_addr_t A_CNT = cp0_pkg::COUNT_ADDR;
localparam cp0_pkg::cp0_addr_t A_CMP = cp0_pkg::COMPARE_ADDR;
localparam cp0_pkg::cp0_addr_t A_BV  = cp0_pkg::BADVADDR_ADDR;
localparam cp0_pkg::cp0_addr_t A_EB  = cp0_pkg::EBASE_ADDR;

localparam cp0_pkg::exc_type_e E_NO = cp0_pkg::NONE;

// EBase keeps bits 31:30 and 11:0 of its reset value
localparam cp0_pkg::cp0_word_t EMASK     = 32'h3FFF_F000;
localparam cp0_pkg::cp0_word_t EBASE_SET = 32'h9001_2345;
localparam cp0_pkg::cp0_word_t EBASE_EXP = (EBASE_RESET & ~EMASK) | (EBASE_SET & EMASK);
localparam cp0_pkg::cp0_word_t XA_BEV    = cp0_pkg::BEV_EX_BASE + cp0_pkg::GENERAL_EX_OFFSET;
localparam cp0_pkg::cp0_word_t XA_EB     = EBASE_EXP + cp0_pkg::GENERAL_EX_OFFSET;
localparam cp0_pkg::cp0_word_t TIMER_CMP = 32'h0000_0100 + TIMER_GAP;

task automatic load_cases();
    // name, op, addr, data, mask, pc, exc, ds, ext, rdata, exc_addr, eret_flush, int_req
    add_row("st_rst", OP_RD, A_ST, 0, 0, 0, E_NO, 0, 0, 32'h0040_0000, XA_BEV, 0, 0);
    add_row("cmp_rst", OP_RD, A_CMP, 0, 0, 0, E_NO, 0, 0, 32'hFFFF_FFFF, XA_BEV, 0, 0);
    add_row("unknown", OP_RD, 8'hA0, 0, 0, 0, E_NO, 0, 0, 0, XA_BEV, 0, 0);
    add_row("epc_rnd", OP_WR, A_EPC, 0, 32'hFFFF_FFFF, 0, E_NO, 0, 0, 0, XA_BEV, 0, 0);
    add_row("cmp_rnd", OP_WR, A_CMP, 0, 32'hFFFF_FFFF, 0, E_NO, 0, 0, 0, XA_BEV, 0, 0);
    add_row("ebase_rnd", OP_WR, A_EB, 0, EMASK, 0, E_NO, 0, 0, EBASE_RESET, XA_BEV, 0, 0);
    add_row("ebase_set", OP_WR, A_EB, EBASE_SET, 0, 0, E_NO, 0, 0, EBASE_EXP, XA_BEV, 0, 0);
    add_row("status_ie", OP_WR, A_ST, 32'h8001, 0, 0, E_NO, 0, 0, 32'h8001, XA_EB, 0, 0);
    add_row("cause_sw", OP_WR, A_CA, 32'h0100, 0, 0, E_NO, 0, 0, 32'h0100, XA_EB, 0, 0);
    add_row("im_sw", OP_WR, A_ST, 32'h0101, 0, 0, E_NO, 0, 0, 32'h0101, XA_EB, 0, 1);
    add_row("cause_clr", OP_WR, A_CA, 0, 0, 0, E_NO, 0, 0, 0, XA_EB, 0, 0);
    add_row("ext_ip4", OP_RD, A_CA, 0, 0, 0, E_NO, 0, 4, 32'h1000, XA_EB, 0, 0);
    add_row("im_ext", OP_WR, A_ST, 32'h1001, 0, 0, E_NO, 0, 4, 32'h1001, XA_EB, 0, 1);
    add_row("ext_off", OP_RD, A_CA, 0, 0, 0, E_NO, 0, 0, 0, XA_EB, 0, 0);
    add_row("exc_sys", OP_EX, A_EPC, 0, 0, 32'h0040_0100, cp0_pkg::SYS, 0, 0,
            32'h0040_0100, XA_EB, 0, 0);
    add_row("cause_sys", OP_RD, A_CA, 0, 0, 0, E_NO, 0, 0, 32'h20, XA_EB, 0, 0);
    add_row("st_exl", OP_RD, A_ST, 0, 0, 0, E_NO, 0, 0, 32'h1003, XA_EB, 0, 0);
    add_row("exc_nest", OP_EX, A_EPC, 0, 0, 32'h0040_0200, cp0_pkg::OV, 1, 0,
            32'h0040_0100, XA_EB, 0, 0);
    add_row("cause_ov", OP_RD, A_CA, 0, 0, 0, E_NO, 0, 0, 32'h30, XA_EB, 0, 0);
    add_row("eret_1", OP_ER, A_ST, 0, 0, 0, E_NO, 0, 0, 32'h1001, XA_EB, 1, 0);
    add_row("eret_exc", OP_ER, A_EPC, 0, 0, 32'h0040_0300, cp0_pkg::RI, 0, 0,
            32'h0040_0300, XA_EB, 0, 0);
    add_row("eret_2", OP_ER, A_ST, 0, 0, 0, E_NO, 0, 0, 32'h1001, XA_EB, 1, 0);
    add_row("exc_bd", OP_EX, A_EPC, 0, 0, 32'h0040_0404, cp0_pkg::BP, 1, 0,
            32'h0040_0400, XA_EB, 0, 0);
    add_row("cause_bd", OP_RD, A_CA, 0, 0, 0, E_NO, 0, 0, 32'h8000_0024, XA_EB, 0, 0);
    add_row("eret_3", OP_ER, A_ST, 0, 0, 0, E_NO, 0, 0, 32'h1001, XA_EB, 1, 0);
    add_row("mtc0_drop", OP_WR, A_EB, 32'h3FFF_F000, 0, 32'h0040_0500, cp0_pkg::SYS, 0, 0,
            EBASE_EXP, XA_EB, 0, 0);
    add_row("eret_4", OP_ER, A_ST, 0, 0, 0, E_NO, 0, 0, 32'h1001, XA_EB, 1, 0);
    add_row("int_mtc0", OP_WR, A_EPC, 32'h1234_5678, 0, 32'h0040_0900, cp0_pkg::INT, 0, 0,
            32'h0040_0904, XA_EB, 0, 0);
    add_row("ades", OP_EX, A_BV, 32'h1003, 0, 32'h0040_0600, cp0_pkg::ADES, 0, 0,
            32'h1003, XA_EB, 0, 0);
    add_row("adel_pc", OP_EX, A_BV, 32'h2000, 0, 32'h0040_0702, cp0_pkg::ADEL, 0, 0,
            32'h0040_0702, XA_EB, 0, 0);
    add_row("adel_data", OP_EX, A_BV, 32'h2001, 0, 32'h0040_0800, cp0_pkg::ADEL, 0, 0,
            32'h2001, XA_EB, 0, 0);
    add_row("eret_5", OP_ER, A_ST, 0, 0, 0, E_NO, 0, 0, 32'h1001, XA_EB, 1, 0);
    add_row("status_tm", OP_WR, A_ST, 32'h8001, 0, 0, E_NO, 0, 0, 32'h8001, XA_EB, 0, 0);
    add_row("count_set", OP_WR, A_CNT, 32'h0100, 0, 0, E_NO, 0, 0, 32'h0100, XA_EB, 0, 0);
    add_row("cmp_set", OP_WR, A_CMP, TIMER_CMP, 0, 0, E_NO, 0, 0, TIMER_CMP, XA_EB, 0, 0);
    add_row("tmr_wait", OP_WT, A_CA, 0, 0, 0, E_NO, 0, 0, 32'h4000_8010, XA_EB, 0, 1);
    add_row("cmp_ack", OP_WR, A_CMP, 32'h8000_0000, 0, 0, E_NO, 0, 0, 32'h8000_0000,
            XA_EB, 0, 1);
    add_row("ack_done", OP_RD, A_CA, 0, 0, 0, E_NO, 0, 0, 32'h10, XA_EB, 0, 0);
endtask

`endif

//--- sim/tb_cp0.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cp0;

    localparam cp0_pkg::cp0_word_t EBASE_RESET = cp0_pkg::EBASE_RESET;
    localparam int COUNT_DIV  = cp0_pkg::COUNT_DIV;
    localparam int TIMER_GAP  = 4;                        // Compare minus Count in the timer rows
    localparam int WAIT_BOUND = COUNT_DIV * TIMER_GAP + 3;

    localparam int OP_RD = 0;
    localparam int OP_WR = 1;
    localparam int OP_EX = 2;
    localparam int OP_ER = 3;
    localparam int OP_WT = 4;

    logic                clk;
    logic                reset;
    cp0_pkg::mem_stage_t mem;
    logic [5:0]          ext_int;
    cp0_pkg::cp0_word_t  rdata;
    cp0_pkg::cp0_word_t  exc_addr;
    cp0_pkg::cp0_word_t  epc;
    logic                eret_flush;
    logic                int_req;

    string               names[$];
    int                  cycles = 0;
    int                  limit = 100000;
    integer              seed = 32'h7a3;

    `include "tb_cp0_cases.svh"

    case_t               rows[$];

    cp0_top #(
        .EBASE_RESET (EBASE_RESET),
        .COUNT_DIV   (COUNT_DIV)
    ) dut_i (
        .clk        (clk),
        .reset      (reset),
        .mem        (mem),
        .ext_int    (ext_int),
        .rdata      (rdata),
        .exc_addr   (exc_addr),
        .epc        (epc),
        .eret_flush (eret_flush),
        .int_req    (int_req)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic add_row(input string name, input int op, input cp0_pkg::cp0_addr_t addr,
                           input cp0_pkg::cp0_word_t data, input cp0_pkg::cp0_word_t mask,
                           input cp0_pkg::cp0_word_t pc, input cp0_pkg::exc_type_e exc,
                           input int ds, input int ext, input cp0_pkg::cp0_word_t exp_rd,
                           input cp0_pkg::cp0_word_t exp_xa, input int flush, input int irq);
        case_t r;
        r.op = op;
        r.addr = addr;
        r.data = data;
        r.mask = mask;
        r.pc = pc;
        r.exc = exc;
        r.ds = ds[0];
        r.ext = ext[5:0];
        r.exp_rd = exp_rd;
        r.exp_xa = exp_xa;
        r.exp_flush = flush[0];
        r.exp_int = irq[0];
        rows.push_back(r);
        names.push_back(name);
    endtask

    task automatic check_word(input string name, input string what,
                              input cp0_pkg::cp0_word_t exp, input cp0_pkg::cp0_word_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s %s expected %h actual %h", name, what, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "%s mismatch", what);
        end
    endtask

    task automatic check_bit(input string name, input string what, input bit exp, input bit act);
        if (act !== exp) begin
            $display("CHECK FAILED %s %s expected %b actual %b", name, what, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "%s mismatch", what);
        end
    endtask

    // One memory-stage slot with valid low for a stall
    task automatic drive_mem(input case_t c, input logic valid);
        cp0_pkg::mem_stage_t m;
        m = '0;
        m.valid = valid;
        m.is_mtc0 = (c.op == OP_WR);
        m.is_eret = (c.op == OP_ER);
        m.in_delay_slot = c.ds;
        m.exc = c.exc;
        m.rd_sel = c.addr;
        m.pc = c.pc;
        m.alu_result = c.data;
        mem <= m;
        ext_int <= c.ext;
    endtask

    task automatic wait_for_int(input string name);
        int n;
        n = 0;
        @(negedge clk);
        while (!int_req && n < WAIT_BOUND) begin
            @(negedge clk);
            n++;
        end
        if (!int_req) begin
            $display("%s: timer interrupt did not rise within %0d cycles", name, WAIT_BOUND);
            $display("ERRORS FOUND");
            $fatal(1, "timer interrupt missing");
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("Run stopped after %0d cycles without finishing", cycles);
            $display("ERRORS FOUND");
            $fatal(1, "timeout");
        end
    end

    initial begin
        case_t c;
        reset = 1'b1;
        mem = '0;
        ext_int = 6'd0;
        load_cases();
        limit = rows.size() * (WAIT_BOUND + 3) + 20;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            c = rows[i];
            if (c.mask != 0) begin
                c.data = $random(seed);
                c.exp_rd = (c.exp_rd & ~c.mask) | (c.data & c.mask);
            end
            @(posedge clk);
            if (c.op == OP_WT) begin
                drive_mem(c, 1'b0);
                wait_for_int(names[i]);
            end else begin
                drive_mem(c, c.op != OP_RD);
                @(negedge clk);
                check_bit(names[i], "eret_flush", c.exp_flush, eret_flush);
                @(posedge clk);
                drive_mem(c, 1'b0);                        // Read back after the commit edge
                @(negedge clk);
            end
            check_word(names[i], "rdata", c.exp_rd, rdata);
            check_word(names[i], "exc_addr", c.exp_xa, exc_addr);
            check_bit(names[i], "int_req", c.exp_int, int_req);
            if (c.addr == A_EPC) begin
                check_word(names[i], "epc", c.exp_rd, epc);
            end
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/tb_cp0_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_checker (
    input wire                 clk,
    input wire                 reset,
    input cp0_pkg::mem_stage_t mem,
    input wire                 eret_flush,
    input wire                 int_req,
    input wire                 exl
);

    logic exc_valid;

    assign exc_valid = mem.valid && (mem.exc != cp0_pkg::NONE);

    // ERET is squashed by its own exception
    flush_no_exc: assert property (@(posedge clk) disable iff (reset)
        !(eret_flush && exc_valid))
        else $error("eret_flush together with an exception");

    reset_quiet: assert property (@(posedge clk)
        (reset && $past(reset)) |-> (!int_req && !eret_flush))
        else $error("int_req or eret_flush active in reset");

    exc_sets_exl: assert property (@(posedge clk) disable iff (reset)
        exc_valid |=> exl)
        else $error("EXL not set after an exception");

endmodule

bind cp0_top cp0_checker chk_i (
    .clk        (clk),
    .reset      (reset),
    .mem        (mem),
    .eret_flush (eret_flush),
    .int_req    (int_req),
    .exl        (sv.exl)
);

`default_nettype wire

//--- timer/cp0_timer.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_timer #(
    parameter int COUNT_DIV = cp0_pkg::COUNT_DIV
) (
    input  wire                  clk,
    input  wire                  reset,
    input  cp0_pkg::cp0_write_t  wr,
    input  wire [5:0]            ext_int,
    output cp0_pkg::timer_view_t tv
);

    localparam int DIV_W = (COUNT_DIV > 1) ? $clog2(COUNT_DIV) : 1;

    logic [DIV_W-1:0]   div_cnt;
    logic               tick;
    cp0_pkg::cp0_word_t count;
    cp0_pkg::cp0_word_t compare;
    logic               ti;
    logic [7:0]         ip;
    logic               count_we;
    logic               compare_we;
    logic               cause_we;

    assign count_we   = wr.we && (wr.addr == cp0_pkg::COUNT_ADDR);
    assign compare_we = wr.we && (wr.addr == cp0_pkg::COMPARE_ADDR);
    assign cause_we   = wr.we && (wr.addr == cp0_pkg::CAUSE_ADDR);

    assign tick = (div_cnt == DIV_W'(COUNT_DIV - 1));

    // Free-running prescaler, Count advances once per COUNT_DIV cycles
    always_ff @(posedge clk) begin
        if (reset || tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= 32'd0;
        end else if (count_we) begin
            count <= wr.data;
        end else if (tick) begin
            count <= count + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            compare <= 32'hFFFF_FFFF;               // Far away from Count at start
        end else if (compare_we) begin
            compare <= wr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ti <= 1'b0;
        end else if (compare_we) begin
            ti <= 1'b0;                             // Acknowledge by rewriting Compare
        end else if (count == compare) begin
            ti <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ip <= 8'h00;
        end else begin
            ip[7]   <= ext_int[5] | ti;             // Timer shares line 5
            ip[6:2] <= ext_int[4:0];
            if (cause_we) begin
                ip[1:0] <= wr.data[9:8];            // Software interrupts
            end
        end
    end

    assign tv.count   = count;
    assign tv.compare = compare;
    assign tv.ti      = ti;
    assign tv.ip      = ip;

endmodule

`default_nettype wire

//--- verilog/cp0_reg_view.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_reg_view (
    input  cp0_pkg::cp0_addr_t    rd_sel,
    input  cp0_pkg::status_view_t sv,
    input  cp0_pkg::timer_view_t  tv,
    output cp0_pkg::cp0_word_t    rdata,
    output cp0_pkg::cp0_word_t    exc_addr,
    output logic                  int_req
);

    cp0_pkg::cp0_word_t status_word;
    cp0_pkg::cp0_word_t cause_word;
    cp0_pkg::cp0_word_t exc_base;

    // Architectural layouts, unused bits read as zero
    assign status_word = {9'd0, sv.bev, 6'd0, sv.im, 6'd0, sv.exl, sv.ie};
    assign cause_word  = {sv.bd, tv.ti, 14'd0, tv.ip, 1'b0, sv.exc_code, 2'b00};

    always_comb begin
        case (rd_sel)
            cp0_pkg::STATUS_ADDR:   rdata = status_word;
            cp0_pkg::CAUSE_ADDR:    rdata = cause_word;
            cp0_pkg::EPC_ADDR:      rdata = sv.epc;
            cp0_pkg::COUNT_ADDR:    rdata = tv.count;
            cp0_pkg::COMPARE_ADDR:  rdata = tv.compare;
            cp0_pkg::BADVADDR_ADDR: rdata = sv.badvaddr;
            cp0_pkg::EBASE_ADDR:    rdata = sv.ebase;
            default:                rdata = 32'd0;    // Unimplemented register
        endcase
    end

    assign exc_base = sv.bev ? cp0_pkg::BEV_EX_BASE : sv.ebase;
    assign exc_addr = exc_base + cp0_pkg::GENERAL_EX_OFFSET;

    // Masked pending lines, blocked inside a handler
    assign int_req = sv.ie && !sv.exl && |(tv.ip & sv.im);

endmodule

`default_nettype wire

//--- verilog/cp0_top.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_top #(
    parameter cp0_pkg::cp0_word_t EBASE_RESET = cp0_pkg::EBASE_RESET,
    parameter int                 COUNT_DIV   = cp0_pkg::COUNT_DIV
) (
    input  wire                 clk,
    input  wire                 reset,
    input  cp0_pkg::mem_stage_t mem,
    input  wire [5:0]           ext_int,
    output cp0_pkg::cp0_word_t  rdata,
    output cp0_pkg::cp0_word_t  exc_addr,
    output cp0_pkg::cp0_word_t  epc,
    output logic                eret_flush,
    output logic                int_req
);

    cp0_pkg::cp0_write_t   wr;
    cp0_pkg::status_view_t sv;
    cp0_pkg::timer_view_t  tv;

    cp0_exception_unit #(
        .EBASE_RESET (EBASE_RESET)
    ) u_exc (
        .clk        (clk),
        .reset      (reset),
        .mem        (mem),
        .wr         (wr),
        .sv         (sv),
        .eret_flush (eret_flush)
    );

    cp0_timer #(
        .COUNT_DIV (COUNT_DIV)
    ) u_timer (
        .clk     (clk),
        .reset   (reset),
        .wr      (wr),                  // Committed MTC0 only
        .ext_int (ext_int),
        .tv      (tv)
    );

    cp0_reg_view u_view (
        .rd_sel   (mem.rd_sel),
        .sv       (sv),
        .tv       (tv),
        .rdata    (rdata),
        .exc_addr (exc_addr),
        .int_req  (int_req)
    );

    assign epc = sv.epc;

endmodule

`default_nettype wire
